/* Bender.yml */
package:
  name: esc_pwm

sources:
  # Design sources in compile order
  - files:
      - design/esc_pkg.sv
      - design/pwm_timebase.sv
      - design/pwm_channel.sv
      - design/failsafe_ramp.sv
      - design/motor_rate_bank.sv
      - design/esc_pwm_top.sv

  # Testbench, simulation only
  - target: test
    files:
      - verif/esc_pwm_tb.sv

/* design/esc_pkg.sv */
package esc_pkg;

  // Motor count for the drive block
  localparam int num_motors = 4;

  // Last value of the period counter
  // One frame is pwm_period_us + 1 microseconds
  localparam int pwm_period_us = 2499;

  // Pulse high time at rate zero
  localparam int min_high_us = 1000;

  // Rate to microseconds, four per step
  localparam int pulse_shift = 2;

  // Silent frames before the failsafe ramp starts
  localparam int failsafe_frames = 4;

  // Rate decrement applied once per frame while ramping
  localparam int ramp_step = 16;

  // Motor rate command from the host
  typedef logic [7:0] rate_t;

  // Scaled rate, microseconds above the minimum high time
  typedef logic [9:0] pulse_t;

  // Microsecond position inside the frame
  typedef logic [15:0] period_t;

  // Motor select
  typedef logic [1:0] motor_idx_t;

  // All current rates, element i drives motor i
  typedef rate_t [num_motors-1:0] motor_rates_t;

  // Single-cycle rate write strobe
  typedef struct packed {
    logic       en;
    motor_idx_t idx;
    rate_t      rate;
  } rate_wr_t;

  // Failsafe FSM
  typedef enum logic [1:0] {
    // Counting frames since the last host write
    fs_watch,
    // Active, waiting for the next frame boundary
    fs_ramp,
    // Active, one decrement write per cycle
    fs_write
  } fs_state_t;

endpackage

/* design/esc_pwm_top.sv */
`timescale 1ns/1ps

module esc_pwm_top
  import esc_pkg::*;
(
  input  logic                  us_clk,
  input  logic                  resetn,
  input  rate_wr_t              host_wr,
  output logic [num_motors-1:0] motor_pwm,
  output logic                  failsafe_active
);

  // Shared frame timing
  period_t period_count;
  logic    frame_start;

  // Bank contents and failsafe write port
  motor_rates_t rates;
  rate_wr_t     fs_wr;

  // Single microsecond timebase for all motors
  pwm_timebase u_timebase (
    .us_clk       (us_clk),
    .resetn       (resetn),
    .period_count (period_count),
    .frame_start  (frame_start)
  );

  // Rate registers, host and failsafe writers
  motor_rate_bank u_rate_bank (
    .us_clk  (us_clk),
    .resetn  (resetn),
    .host_wr (host_wr),
    .fs_wr   (fs_wr),
    .rates   (rates)
  );

  // Host write strobe is the only liveness signal
  failsafe_ramp u_failsafe (
    .us_clk          (us_clk),
    .resetn          (resetn),
    .frame_start     (frame_start),
    .host_wr_seen    (host_wr.en),
    .rates           (rates),
    .fs_wr           (fs_wr),
    .failsafe_active (failsafe_active)
  );

  // One PWM generator per motor
  for (genvar m = 0; m < num_motors; m++) begin : u_channel
    pwm_channel u_pwm (
      .us_clk       (us_clk),
      .resetn       (resetn),
      .rate         (rates[m]),
      .period_count (period_count),
      .frame_start  (frame_start),
      .pwm          (motor_pwm[m])
    );
  end

endmodule

/* design/failsafe_ramp.sv */
`timescale 1ns/1ps

module failsafe_ramp
  import esc_pkg::*;
(
  input  logic         us_clk,
  input  logic         resetn,
  input  logic         frame_start,
  input  logic         host_wr_seen,
  input  motor_rates_t rates,
  output rate_wr_t     fs_wr,
  output logic         failsafe_active
);

  fs_state_t state_q;
  fs_state_t state_d;

  // Frames seen since the last host write
  logic [$clog2(failsafe_frames + 1)-1:0] silent_cnt;

  // Motor being decremented in fs_write
  motor_idx_t wr_idx;

  // Current rate of the selected motor
  rate_t cur_rate;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      fs_watch: begin
        // Last silent frame allowed
        if (frame_start && (int'(silent_cnt) == failsafe_frames - 1)) begin
          state_d = fs_ramp;
        end
      end
      fs_ramp: begin
        if (frame_start) begin
          state_d = fs_write;
        end
      end
      fs_write: begin
        // All four motors written
        if (wr_idx == motor_idx_t'(num_motors - 1)) begin
          state_d = fs_ramp;
        end
      end
      default: begin
        state_d = fs_watch;
      end
    endcase
    // Any host write means the host is alive again
    if (host_wr_seen) begin
      state_d = fs_watch;
    end
  end

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      state_q <= fs_watch;
    end else begin
      state_q <= state_d;
    end
  end

  // Silent frame counter, cleared on host activity or on leaving watch
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      silent_cnt <= '0;
    end else if (host_wr_seen || (state_q != fs_watch)) begin
      silent_cnt <= '0;
    end else if (frame_start) begin
      silent_cnt <= silent_cnt + 1'b1;
    end
  end

  // Walk motors 0 to 3, wraps to 0 after the last one
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      wr_idx <= '0;
    end else if (state_q == fs_write) begin
      wr_idx <= wr_idx + 1'b1;
    end else begin
      wr_idx <= '0;
    end
  end

  assign cur_rate = rates[wr_idx];

  // Decrement write, saturating at zero
  assign fs_wr.en   = (state_q == fs_write);
  assign fs_wr.idx  = wr_idx;
  assign fs_wr.rate = (cur_rate > rate_t'(ramp_step)) ? (cur_rate - rate_t'(ramp_step)) : '0;

  assign failsafe_active = (state_q != fs_watch);

endmodule

/* design/motor_rate_bank.sv */
`timescale 1ns/1ps

module motor_rate_bank
  import esc_pkg::*;
(
  input  logic         us_clk,
  input  logic         resetn,
  input  rate_wr_t     host_wr,
  input  rate_wr_t     fs_wr,
  output motor_rates_t rates
);

  // Arbiter grants
  logic grant_fs;
  logic grant_host;

  // Write that reaches the registers this cycle
  rate_wr_t win_wr;

  // Fixed priority, failsafe first
  assign grant_fs   = fs_wr.en;
  assign grant_host = host_wr.en && !fs_wr.en;

  // Losing write is dropped, no retry
  always_comb begin
    if (grant_fs) begin
      win_wr = fs_wr;
    end else begin
      win_wr = host_wr;
    end
    win_wr.en = grant_fs || grant_host;
  end

  // One register per motor
  for (genvar m = 0; m < num_motors; m++) begin : g_rate
    // Decoded write enable for this motor
    logic  wr_sel;
    rate_t rate_q;

    assign wr_sel = win_wr.en && (win_wr.idx == motor_idx_t'(m));

    // All motors idle at rate zero after reset
    always_ff @(posedge us_clk or negedge resetn) begin
      if (!resetn) begin
        rate_q <= '0;
      end else if (wr_sel) begin
        rate_q <= win_wr.rate;
      end
    end

    // Visible one cycle after the strobe
    assign rates[m] = rate_q;
  end

endmodule

/* design/pwm_channel.sv */
`timescale 1ns/1ps

module pwm_channel
  import esc_pkg::*;
(
  input  logic    us_clk,
  input  logic    resetn,
  input  rate_t   rate,
  input  period_t period_count,
  input  logic    frame_start,
  output logic    pwm
);

  // Pulse extension held for the whole frame
  pulse_t pulse_q;

  // Count at which the pulse ends
  period_t high_limit;

  // Rate latch, only at the frame boundary
  // Mid-frame rate changes wait for the next frame
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      pulse_q <= '0;
    end else if (frame_start) begin
      pulse_q <= pulse_t'(rate) << pulse_shift;
    end
  end

  // Minimum high time plus scaled rate
  assign high_limit = period_t'(min_high_us) + period_t'(pulse_q);

  // High while the frame position is under the limit
  // Boundary cycle sits at the last count, so output is low there
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      pwm <= 1'b0;
    end else begin
      pwm <= (period_count < high_limit);
    end
  end

endmodule

/* design/pwm_timebase.sv */
`timescale 1ns/1ps

module pwm_timebase
  import esc_pkg::*;
(
  input  logic    us_clk,
  input  logic    resetn,
  output period_t period_count,
  output logic    frame_start
);

  // Count value for the next cycle
  period_t count_next;

  // Last count of the frame
  logic last_count;

  assign last_count = (period_count == period_t'(pwm_period_us));

  // Wrap back to zero after the last microsecond
  always_comb begin
    if (last_count) begin
      count_next = '0;
    end else begin
      count_next = period_count + 1'b1;
    end
  end

  // Free-running microsecond counter
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      period_count <= '0;
    end else begin
      period_count <= count_next;
    end
  end

  // Frame boundary flag
  // Registered one count early so it lines up with the last count
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      frame_start <= 1'b0;
    end else begin
      frame_start <= (count_next == period_t'(pwm_period_us));
    end
  end

endmodule

/* verif/esc_pwm_tb.sv */
`timescale 1ns/1ps

module esc_pwm_tb
  import esc_pkg::*;
();

  localparam int clk_period_ns = 40;
  // Upper bound on frames used by the whole sequence
  localparam int test_frames   = 52;
  localparam int min_pulses    = 40;
  localparam longint watchdog_ns =
    longint'(test_frames + 2) * (pwm_period_us + 1) * clk_period_ns;

  // One finished pulse as seen on a motor output
  typedef struct packed {
    motor_idx_t motor;
    period_t    width;
    period_t    exp_width;
    logic       has_period;
    period_t    period;
  } pulse_rec_t;

  logic                  us_clk;
  logic                  resetn;
  rate_wr_t              host_wr;
  logic [num_motors-1:0] motor_pwm;
  logic                  failsafe_active;

  int seed = 62;

  // Reference model state
  rate_t   shadow [num_motors];
  rate_t   latched [num_motors];
  int      silent;
  logic    model_active;
  period_t tb_pos;
  int      cyc;
  int      frame_cnt;

  // Pulses waiting for the compare process
  pulse_rec_t done_q [$];
  int         pulse_cnt [num_motors];

  esc_pwm_top u_esc_pwm_top (
    .us_clk          (us_clk),
    .resetn          (resetn),
    .host_wr         (host_wr),
    .motor_pwm       (motor_pwm),
    .failsafe_active (failsafe_active)
  );

  initial begin
    us_clk = 1'b0;
    forever #(clk_period_ns / 2) us_clk = ~us_clk;
  end

  // Pulse high time for a latched rate
  function automatic period_t expected_width(rate_t rate);
    return period_t'(min_high_us + 4 * int'(rate));
  endfunction

  task automatic stop_on_error();
    $display("** FAIL **");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_width(input motor_idx_t motor, input period_t exp_w, input period_t act_w);
    if (act_w !== exp_w) begin
      $display("error: motor_pwm[%0d] width expected %h actual %h", motor, exp_w, act_w);
      stop_on_error();
    end
  endtask

  task automatic check_period(input motor_idx_t motor, input period_t exp_p, input period_t act_p);
    if (act_p !== exp_p) begin
      $display("error: motor_pwm[%0d] period expected %h actual %h", motor, exp_p, act_p);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input logic exp_f, input logic act_f);
    if (act_f !== exp_f) begin
      $display("error: failsafe_active expected %h actual %h", exp_f, act_f);
      stop_on_error();
    end
  endtask

  task automatic check_pwm(input logic [num_motors-1:0] exp_v, input logic [num_motors-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("error: motor_pwm expected %h actual %h", exp_v, act_v);
      stop_on_error();
    end
  endtask

  // Single-cycle write strobe from a falling edge
  task automatic host_write(input motor_idx_t motor, input rate_t value);
    host_wr = '{en: 1'b1, idx: motor, rate: value};
    @(negedge us_clk);
    host_wr = '0;
  endtask

  // Frame boundaries counted by the model
  task automatic wait_frames(input int n);
    int target;
    target = frame_cnt + n;
    while (frame_cnt < target) begin
      @(negedge us_clk);
    end
  endtask

  // Next time the model frame position hits p
  task automatic wait_pos(input period_t p);
    do begin
      @(negedge us_clk);
    end while (tb_pos != p);
  endtask

  // Model of timebase, rate bank and failsafe rule
  always @(posedge us_clk or negedge resetn) begin
    int v;
    if (!resetn) begin
      for (int m = 0; m < num_motors; m++) begin
        shadow[m]  = '0;
        latched[m] = '0;
      end
      silent       = 0;
      model_active = 1'b0;
      tb_pos       = '0;
      cyc          = 0;
      frame_cnt    = 0;
    end else begin
      cyc++;
      // Channels take the rate held before this edge
      if (tb_pos == period_t'(pwm_period_us)) begin
        for (int m = 0; m < num_motors; m++) begin
          latched[m] = shadow[m];
        end
        frame_cnt++;
      end
      if (host_wr.en) begin
        shadow[host_wr.idx] = host_wr.rate;
        silent       = 0;
        model_active = 1'b0;
      end else if (tb_pos == period_t'(pwm_period_us)) begin
        if (model_active) begin
          // Ramp lands before the next latch
          for (int m = 0; m < num_motors; m++) begin
            v = int'(shadow[m]) - ramp_step;
            shadow[m] = (v < 0) ? rate_t'(0) : rate_t'(v);
          end
        end else begin
          silent++;
          if (silent == failsafe_frames) begin
            model_active = 1'b1;
            silent       = 0;
          end
        end
      end
      tb_pos = (tb_pos == period_t'(pwm_period_us)) ? period_t'(0) : tb_pos + 1'b1;
    end
  end

  // Edge timing per motor on the falling edge
  for (genvar m = 0; m < num_motors; m++) begin : g_meas
    logic    pwm_prev;
    logic    seen_rise;
    int      rise_cyc;
    period_t exp_w;
    period_t per;
    logic    has_per;

    always @(negedge us_clk or negedge resetn) begin
      pulse_rec_t rec;
      if (!resetn) begin
        pwm_prev  = 1'b0;
        seen_rise = 1'b0;
        has_per   = 1'b0;
      end else begin
        if (motor_pwm[m] && !pwm_prev) begin
          // Expected width fixed by the rate latched for this frame
          has_per   = seen_rise;
          per       = period_t'(cyc - rise_cyc);
          rise_cyc  = cyc;
          seen_rise = 1'b1;
          exp_w     = expected_width(latched[m]);
        end else if (!motor_pwm[m] && pwm_prev) begin
          rec.motor      = motor_idx_t'(m);
          rec.width      = period_t'(cyc - rise_cyc);
          rec.exp_width  = exp_w;
          rec.has_period = has_per;
          rec.period     = per;
          done_q.push_back(rec);
        end
        pwm_prev = motor_pwm[m];
      end
    end
  end

  // Compare finished pulses against the model
  always @(posedge us_clk) begin
    pulse_rec_t rec;
    while (done_q.size() > 0) begin
      rec = done_q.pop_front();
      check_width(rec.motor, rec.exp_width, rec.width);
      if (rec.has_period) begin
        check_period(rec.motor, period_t'(pwm_period_us + 1), rec.period);
      end
      pulse_cnt[rec.motor]++;
    end
  end

  // Flag follows the failsafe rule every cycle
  always @(negedge us_clk) begin
    if (resetn) begin
      check_flag(model_active, failsafe_active);
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the test sequence finished");
    $display("** FAIL **");
    $fatal(1, "timeout");
  end

  initial begin
    rate_t r;
    resetn  = 1'b0;
    host_wr = '0;
    for (int m = 0; m < num_motors; m++) begin
      pulse_cnt[m] = 0;
    end
    repeat (10) @(negedge us_clk);
    // Outputs idle while reset is held
    check_pwm('0, motor_pwm);
    check_flag(1'b0, failsafe_active);
    resetn = 1'b1;

    // Rate zero frames after reset
    wait_frames(3);

    // Random rates written during the pulse in progress
    repeat (4) begin
      wait_pos(period_t'(600));
      for (int m = 0; m < num_motors; m++) begin
        r = rate_t'($random(seed));
        host_write(motor_idx_t'(m), r);
      end
    end
    wait_frames(2);

    // End point rates and three writes to motor 2 in one frame
    wait_pos(period_t'(700));
    host_write(2'd0, 8'd0);
    host_write(2'd1, 8'd255);
    host_write(2'd2, 8'd10);
    host_write(2'd2, 8'd200);
    host_write(2'd2, 8'd77);
    host_write(2'd3, 8'd255);
    wait_frames(2);

    // Silent host lets the ramp run down to zero
    wait_frames(26);
    check_flag(1'b1, failsafe_active);

    // Reload all motors and interrupt the ramp once it runs
    wait_pos(period_t'(500));
    for (int m = 0; m < num_motors; m++) begin
      host_write(motor_idx_t'(m), 8'd200);
    end
    wait_frames(7);
    wait_pos(period_t'(800));
    host_write(2'd2, 8'd180);
    check_flag(1'b0, failsafe_active);
    wait_frames(3);

    // Let the last pulses finish and drain
    wait_pos(period_t'(2400));
    @(posedge us_clk);
    @(negedge us_clk);
    for (int m = 0; m < num_motors; m++) begin
      if (pulse_cnt[m] < min_pulses) begin
        $display("motor %0d produced only %0d pulses", m, pulse_cnt[m]);
        stop_on_error();
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule

/* vlog.f */
design/esc_pkg.sv
design/pwm_timebase.sv
design/pwm_channel.sv
design/failsafe_ramp.sv
design/motor_rate_bank.sv
design/esc_pwm_top.sv
verif/esc_pwm_tb.sv
